// ==== src/tlbPkg.sv ====
//////////////////////////////////////////////////
// Shared definitions for the Sv39 TLB
//   Page number, segment and permission widths
//   Page size and operation encodings
//   Page number views for the CAM and the splice
//////////////////////////////////////////////////

package tlbPkg;

  // Sv39 splits the 27-bit virtual page number into three 9-bit segments
  localparam int vpnBits = 27;
  localparam int segBits = 9;
  localparam int ppnBits = 44;

  // Permission field in PTE order: V R W X U G A D, valid in bit 0
  localparam int permBits = 8;
  localparam int permGlobal = 5;

  // Kilo must stay zero so that the CAM can OR the page types of all lines
  typedef enum logic [1:0] {
    kilo = 2'd0,
    mega = 2'd1,
    giga = 2'd2
  } pageType;

  typedef enum logic [1:0] {
    lookup = 2'd0,
    fill   = 2'd1,
    flush  = 2'd2
  } tlbOp;

  // Virtual page number, flat or as segments 2..0 with segment 2 on top
  typedef union packed {
    logic [vpnBits-1:0]      flat;
    logic [2:0][segBits-1:0] seg;
  } vpnWord;

  // Physical page number, flat or split so large pages can take virtual segments
  typedef union packed {
    logic [ppnBits-1:0] flat;
    struct packed {
      logic [ppnBits-2*segBits-1:0] upper;
      logic [1:0][segBits-1:0]      seg;
    } split;
  } ppnWord;

endpackage

// ==== src/tlbLookupIf.sv ====
//////////////////////////////////////////////////
// Lookup bus between the controller and the CAM
//   Key going in, match results coming back
//////////////////////////////////////////////////

`timescale 1ns/1ps

interface tlbLookupIf #(
  parameter int tlbEntries = 8,
  parameter int asidBits = 16
);
  import tlbPkg::*;

  // Key of the request held by the controller
  vpnWord vpn;
  logic [asidBits-1:0] asid;

  // One-hot match lines, or zero on a miss
  logic [tlbEntries-1:0] matchLines;
  logic camHit;
  pageType hitPageType;

  modport ctrl (output vpn, asid, input matchLines, camHit, hitPageType);
  modport cam (input vpn, asid, output matchLines, camHit, hitPageType);

endinterface

// ==== src/tlbCamLine.sv ====
//////////////////////////////////////////////////
// Single CAM entry of the TLB
//   Valid bit, stored key and page type
//   Match masked by the stored page size
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tlbCamLine #(
  parameter int asidBits = 16
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                writeEnable,
  input  logic                flush,
  input  tlbPkg::vpnWord      writeVpn,
  input  logic [asidBits-1:0] writeAsid,
  input  tlbPkg::pageType     writePageType,
  input  logic                writeGlobal,
  input  tlbPkg::vpnWord      lookupVpn,
  input  logic [asidBits-1:0] lookupAsid,
  output logic                match,
  output logic                valid,
  output tlbPkg::pageType     pageTypeRead
);
  import tlbPkg::*;

  vpnWord keyVpn;
  logic [asidBits-1:0] keyAsid;
  logic keyGlobal;
  pageType keyType;
  logic [2:0] segEqual;
  logic asidOk;

  // A flush drops the valid bit only, the stored key is left as it was
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      valid <= 1'b0;
    end else if (writeEnable) begin
      valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (writeEnable) begin
      keyVpn <= writeVpn;
      keyAsid <= writeAsid;
      keyGlobal <= writeGlobal;
      keyType <= writePageType;
    end
  end

  // Compare every segment, the page type then picks which ones count
  always_comb begin
    for (int i = 0; i < 3; i++) begin
      segEqual[i] = (lookupVpn.seg[i] == keyVpn.seg[i]);
    end
  end

  // Global mappings are shared by all address spaces
  assign asidOk = keyGlobal || (lookupAsid == keyAsid);

  // Segment 2 always counts, segment 1 is ignored for gigapages,
  // segment 0 only counts for 4 KiB pages
  assign match = valid && asidOk && segEqual[2] &&
                 (segEqual[1] || keyType == giga) &&
                 (segEqual[0] || keyType != kilo);

  // Report kilo (zero) on a miss so the OR over all lines is the hit type
  assign pageTypeRead = match ? keyType : kilo;

endmodule

// ==== src/tlbCam.sv ====
//////////////////////////////////////////////////
// Fully associative CAM of the TLB
//   One tlbCamLine per entry
//   Match lines, hit and hit page type
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tlbCam #(
  parameter int tlbEntries = 8,
  parameter int asidBits = 16
) (
  input  logic                  clk,
  input  logic                  rst,
  tlbLookupIf.cam               lk,
  input  logic [tlbEntries-1:0] writeEnables,
  input  tlbPkg::pageType       writePageType,
  input  logic                  writeGlobal,
  input  logic [asidBits-1:0]   writeAsid,
  input  logic                  flushCam,
  output logic [tlbEntries-1:0] validLines
);
  import tlbPkg::*;

  pageType lineTypes [tlbEntries];
  logic [1:0] typeOr;

  // Every line stores the full page number whatever its page type,
  // and a fill always writes the key that is being looked up
  for (genvar i = 0; i < tlbEntries; i++) begin : gLine
    tlbCamLine #(.asidBits(asidBits)) line0 (
      .clk(clk),
      .rst(rst),
      .writeEnable(writeEnables[i]),
      .flush(flushCam),
      .writeVpn(lk.vpn),
      .writeAsid(writeAsid),
      .writePageType(writePageType),
      .writeGlobal(writeGlobal),
      .lookupVpn(lk.vpn),
      .lookupAsid(lk.asid),
      .match(lk.matchLines[i]),
      .valid(validLines[i]),
      .pageTypeRead(lineTypes[i])
    );
  end

  // Lines that miss report kilo, which is zero, so a plain OR is enough
  always_comb begin
    typeOr = 2'b00;
    for (int i = 0; i < tlbEntries; i++) begin
      typeOr = typeOr | lineTypes[i];
    end
  end

  assign lk.hitPageType = pageType'(typeOr);
  // No hit is reported in the cycle that clears the valid bits
  assign lk.camHit = (|lk.matchLines) && !flushCam;

endmodule

// ==== src/tlbRam.sv ====
//////////////////////////////////////////////////
// Translation storage of the TLB
//   Physical page number and permission per entry
//   One-hot write, AND-OR read on the match lines
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tlbRam #(
  parameter int tlbEntries = 8
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [tlbEntries-1:0]         writeEnables,
  input  tlbPkg::ppnWord                writePpn,
  input  logic [tlbPkg::permBits-1:0]   writePerm,
  input  logic [tlbEntries-1:0]         matchLines,
  output tlbPkg::ppnWord                readPpn,
  output logic [tlbPkg::permBits-1:0]   readPerm
);
  import tlbPkg::*;

  ppnWord ppnMem [tlbEntries];
  logic [permBits-1:0] permMem [tlbEntries];

  // Writes are held off while the rest of the TLB is in reset
  always_ff @(posedge clk) begin
    for (int i = 0; i < tlbEntries; i++) begin
      if (!rst && writeEnables[i]) begin
        ppnMem[i] <= writePpn;
        permMem[i] <= writePerm;
      end
    end
  end

  ////////////////////////////////////////////////
  // Read port
  ////////////////////////////////////////////////

  // Each entry is masked by its own match line and the results are ORed,
  // a miss therefore reads all zeros
  always_comb begin
    readPpn.flat = '0;
    readPerm = '0;
    for (int i = 0; i < tlbEntries; i++) begin
      readPpn.flat = readPpn.flat | ({ppnBits{matchLines[i]}} & ppnMem[i].flat);
      readPerm = readPerm | ({permBits{matchLines[i]}} & permMem[i]);
    end
  end

endmodule

// ==== src/tlbLru.sv ====
//////////////////////////////////////////////////
// Replacement logic of the TLB
//   Tree pseudo-LRU over all entries
//   Invalid lines are filled first
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tlbLru #(
  parameter int tlbEntries = 8
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [tlbEntries-1:0] validLines,
  input  logic                  touch,
  input  logic [tlbEntries-1:0] touchLines,
  output logic [tlbEntries-1:0] victimLines
);

  localparam int levels = $clog2(tlbEntries);

  // Heap order, root at 0, children of node n at 2n+1 and 2n+2
  // A zero bit points the victim into the left subtree
  logic [tlbEntries-2:0] treeBits;
  logic [levels-1:0] touchIdx;
  logic [levels-1:0] treeIdx;
  logic [tlbEntries-1:0] invalidFirst;
  logic anyInvalid;

  // Touch lines are one-hot, so ORing the indices gives the entry number
  always_comb begin
    touchIdx = '0;
    for (int i = 0; i < tlbEntries; i++) begin
      if (touchLines[i]) begin
        touchIdx = touchIdx | levels'(i);
      end
    end
  end

  // On the path to the touched leaf, every node is turned to the other side
  always_ff @(posedge clk) begin
    if (rst) begin
      treeBits <= '0;
    end else if (touch) begin
      for (int d = 0; d < levels; d++) begin
        treeBits[(1 << d) - 1 + int'(touchIdx >> (levels - d))] <= ~touchIdx[levels-1-d];
      end
    end
  end

  ////////////////////////////////////////////////
  // Victim choice
  ////////////////////////////////////////////////

  // Walk from the root following the direction bits
  always_comb begin
    int node;
    node = 0;
    treeIdx = '0;
    for (int d = 0; d < levels; d++) begin
      treeIdx[levels-1-d] = treeBits[node];
      node = 2 * node + 1 + int'(treeBits[node]);
    end
  end

  // Lowest numbered free line wins over the tree
  always_comb begin
    invalidFirst = '0;
    anyInvalid = 1'b0;
    for (int i = 0; i < tlbEntries; i++) begin
      if (!validLines[i] && !anyInvalid) begin
        invalidFirst[i] = 1'b1;
        anyInvalid = 1'b1;
      end
    end
  end

  assign victimLines = anyInvalid ? invalidFirst : (tlbEntries'(1) << treeIdx);

endmodule

// ==== src/tlbCtrl.sv ====
//////////////////////////////////////////////////
// Request controller of the TLB
//   Four-phase req/ack handshake
//   Lookup, fill and flush sequencing
//   Large page splice of the returned translation
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tlbCtrl #(
  parameter int tlbEntries = 8,
  parameter int asidBits = 16
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        req,
  input  tlbPkg::tlbOp                op,
  input  logic [tlbPkg::vpnBits-1:0]  vpn,
  input  logic [asidBits-1:0]         asid,
  input  logic [tlbPkg::ppnBits-1:0]  ppnIn,
  input  logic [tlbPkg::permBits-1:0] permIn,
  input  tlbPkg::pageType             pageTypeIn,
  output logic                        ack,
  output logic                        hit,
  output logic [tlbPkg::ppnBits-1:0]  ppnOut,
  output logic [tlbPkg::permBits-1:0] permOut,
  tlbLookupIf.ctrl                    lk,
  output logic [tlbEntries-1:0]       writeEnables,
  output tlbPkg::pageType             writePageType,
  output logic                        writeGlobal,
  output logic                        flushCam,
  output tlbPkg::ppnWord              writePpn,
  output logic [tlbPkg::permBits-1:0] writePerm,
  input  logic [tlbEntries-1:0]       victimLines,
  input  tlbPkg::ppnWord              readPpn,
  input  logic [tlbPkg::permBits-1:0] readPerm,
  output logic                        touch,
  output logic [tlbEntries-1:0]       touchLines
);
  import tlbPkg::*;

  localparam logic [1:0] idle = 2'd0;
  localparam logic [1:0] access = 2'd1;
  localparam logic [1:0] done = 2'd2;

  logic [1:0] state;
  logic reqQ;
  tlbOp opQ;
  vpnWord vpnQ;
  logic [asidBits-1:0] asidQ;
  ppnWord ppnQ;
  logic [permBits-1:0] permQ;
  pageType typeQ;
  logic working;
  logic lookupHit;
  ppnWord splicedPpn;

  ////////////////////////////////////////////////
  // Handshake FSM
  ////////////////////////////////////////////////

  // reqQ delays the start by one cycle, so ack comes two edges after req
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
      reqQ <= 1'b0;
      ack <= 1'b0;
      hit <= 1'b0;
    end else begin
      reqQ <= req;
      case (state)
        idle: begin
          if (reqQ) begin
            state <= access;
          end
        end
        access: begin
          // CAM writes, flush and LRU update all land on this edge
          ack <= 1'b1;
          hit <= lookupHit;
          state <= done;
        end
        done: begin
          // Stay here for as long as the requester holds req
          if (!req) begin
            ack <= 1'b0;
            hit <= 1'b0;
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // The request fields are stable while req is high, so idle just keeps sampling
  always_ff @(posedge clk) begin
    if (state == idle) begin
      opQ <= op;
      vpnQ.flat <= vpn;
      asidQ <= asid;
      ppnQ.flat <= ppnIn;
      permQ <= permIn;
      typeQ <= pageTypeIn;
    end
    if (working) begin
      ppnOut <= lookupHit ? splicedPpn.flat : '0;
      permOut <= lookupHit ? readPerm : '0;
    end
  end

  ////////////////////////////////////////////////
  // Datapath control
  ////////////////////////////////////////////////

  assign working = (state == access);
  assign lk.vpn = vpnQ;
  assign lk.asid = asidQ;
  assign lookupHit = working && (opQ == lookup) && lk.camHit;
  assign flushCam = working && (opQ == flush);

  // A key that already hits is rewritten in place, otherwise the victim is used
  assign writeEnables = (working && opQ == fill) ?
                        (lk.camHit ? lk.matchLines : victimLines) : '0;
  assign writePageType = typeQ;
  assign writeGlobal = permQ[permGlobal];
  assign writePpn = ppnQ;
  assign writePerm = permQ;

  // Both a lookup hit and a fill count as a use of the line
  assign touch = lookupHit || (working && opQ == fill);
  assign touchLines = (opQ == fill) ? writeEnables : lk.matchLines;

  // Megapages and gigapages pass the low virtual segments straight through
  always_comb begin
    splicedPpn = readPpn;
    if (lk.hitPageType == mega) begin
      splicedPpn.split.seg[0] = vpnQ.seg[0];
    end else if (lk.hitPageType == giga) begin
      splicedPpn.split.seg[0] = vpnQ.seg[0];
      splicedPpn.split.seg[1] = vpnQ.seg[1];
    end
  end

endmodule

// ==== src/tlb.sv ====
//////////////////////////////////////////////////
// Top level of the Sv39 TLB
//   Controller, CAM, translation RAM, pseudo-LRU
//   Plain req/ack handshake ports
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tlb #(
  parameter int tlbEntries = 8,
  parameter int asidBits = 16
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        req,
  input  tlbPkg::tlbOp                op,
  input  logic [tlbPkg::vpnBits-1:0]  vpn,
  input  logic [asidBits-1:0]         asid,
  input  logic [tlbPkg::ppnBits-1:0]  ppnIn,
  input  logic [tlbPkg::permBits-1:0] permIn,
  input  tlbPkg::pageType             pageTypeIn,
  output logic                        ack,
  output logic                        hit,
  output logic [tlbPkg::ppnBits-1:0]  ppnOut,
  output logic [tlbPkg::permBits-1:0] permOut
);
  import tlbPkg::*;

  logic [tlbEntries-1:0] writeEnables;
  pageType writePageType;
  logic writeGlobal;
  logic flushCam;
  ppnWord writePpn;
  logic [permBits-1:0] writePerm;
  logic [tlbEntries-1:0] validLines;
  logic [tlbEntries-1:0] victimLines;
  logic touch;
  logic [tlbEntries-1:0] touchLines;
  ppnWord readPpn;
  logic [permBits-1:0] readPerm;

  tlbLookupIf #(.tlbEntries(tlbEntries), .asidBits(asidBits)) lookupBus ();

  tlbCtrl #(.tlbEntries(tlbEntries), .asidBits(asidBits)) ctrl0 (
    .clk(clk),
    .rst(rst),
    .req(req),
    .op(op),
    .vpn(vpn),
    .asid(asid),
    .ppnIn(ppnIn),
    .permIn(permIn),
    .pageTypeIn(pageTypeIn),
    .ack(ack),
    .hit(hit),
    .ppnOut(ppnOut),
    .permOut(permOut),
    .lk(lookupBus.ctrl),
    .writeEnables(writeEnables),
    .writePageType(writePageType),
    .writeGlobal(writeGlobal),
    .flushCam(flushCam),
    .writePpn(writePpn),
    .writePerm(writePerm),
    .victimLines(victimLines),
    .readPpn(readPpn),
    .readPerm(readPerm),
    .touch(touch),
    .touchLines(touchLines)
  );

  // A fill writes the ASID of the latched request that is on the lookup bus
  tlbCam #(.tlbEntries(tlbEntries), .asidBits(asidBits)) cam0 (
    .clk(clk),
    .rst(rst),
    .lk(lookupBus.cam),
    .writeEnables(writeEnables),
    .writePageType(writePageType),
    .writeGlobal(writeGlobal),
    .writeAsid(lookupBus.asid),
    .flushCam(flushCam),
    .validLines(validLines)
  );

  tlbRam #(.tlbEntries(tlbEntries)) ram0 (
    .clk(clk),
    .rst(rst),
    .writeEnables(writeEnables),
    .writePpn(writePpn),
    .writePerm(writePerm),
    .matchLines(lookupBus.matchLines),
    .readPpn(readPpn),
    .readPerm(readPerm)
  );

  tlbLru #(.tlbEntries(tlbEntries)) lru0 (
    .clk(clk),
    .rst(rst),
    .validLines(validLines),
    .touch(touch),
    .touchLines(touchLines),
    .victimLines(victimLines)
  );

endmodule

// ==== verification/tlbChk.sv ====
//////////////////////////////////////////////////
// Protocol assertions for the TLB top level
//   Fixed ack latency after req
//   Ack held under back-pressure
//   Hit only visible together with ack
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tlbChk (
  input logic clk,
  input logic rst,
  input logic req,
  input logic ack,
  input logic hit
);

  // The register sets ack two edges after req is first sampled,
  // and the sampled value of ack shows it one edge later still
  ackLatency: assert property (
    @(posedge clk) disable iff (rst) $rose(req) |-> !ack [*3] ##1 ack
  ) else $error("ack did not follow req after the fixed latency");

  // While the requester holds req the result must not go away
  ackHeld: assert property (
    @(posedge clk) disable iff (rst) (ack && req) |=> ack
  ) else $error("ack dropped while req was still high");

  // Hit is a result and only has a meaning while ack is high
  hitWithAck: assert property (
    @(posedge clk) disable iff (rst) !ack |-> !hit
  ) else $error("hit was high while ack was low");

endmodule

bind tlb tlbChk chk0 (
  .clk(clk),
  .rst(rst),
  .req(req),
  .ack(ack),
  .hit(hit)
);

// ==== verification/tlbTb.sv ====
//////////////////////////////////////////////////
// Testbench for the Sv39 TLB
//   Clock, reset and xorshift stimulus
//   Reference model with pseudo-LRU tree
//   Handshake driver, check task and timeout
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tlbTb;
  import tlbPkg::*;

  localparam int entries = 8;
  localparam int asidW = 16;
  localparam int levels = $clog2(entries);

  // Operation counts per phase give the timeout
  localparam int resetLookups = 4;
  localparam int evictRounds = 12;
  localparam int refillCount = 4;
  localparam int postFlushFills = 4;
  localparam int opCount = resetLookups + 4 * entries + evictRounds * 3 +
                           refillCount * 2 + 1 + entries + postFlushFills * 2;
  localparam int timeoutLimit = 12 * opCount + 100;

  logic clk;
  logic rst;
  logic req;
  tlbOp op;
  logic [vpnBits-1:0] vpn;
  logic [asidW-1:0] asid;
  logic [ppnBits-1:0] ppnIn;
  logic [permBits-1:0] permIn;
  pageType pageTypeIn;
  logic ack;
  logic hit;
  logic [ppnBits-1:0] ppnOut;
  logic [permBits-1:0] permOut;

  logic [31:0] rngState = 32'd75;
  int cycleCount = 0;

  ////////////////////////////////////////////////
  // Reference model state
  ////////////////////////////////////////////////

  logic mValid [entries];
  logic [vpnBits-1:0] mVpn [entries];
  logic [asidW-1:0] mAsid [entries];
  logic mGlobal [entries];
  pageType mType [entries];
  logic [ppnBits-1:0] mPpn [entries];
  logic [permBits-1:0] mPerm [entries];
  logic [entries-2:0] mTree;

  // Key of the latest fill and of the line it pushed out
  logic [vpnBits-1:0] lastVpn;
  logic [asidW-1:0] lastAsid;
  logic [vpnBits-1:0] evictedVpn;
  logic [asidW-1:0] evictedAsid;

  tlb dut0 (
    .clk(clk),
    .rst(rst),
    .req(req),
    .op(op),
    .vpn(vpn),
    .asid(asid),
    .ppnIn(ppnIn),
    .permIn(permIn),
    .pageTypeIn(pageTypeIn),
    .ack(ack),
    .hit(hit),
    .ppnOut(ppnOut),
    .permOut(permOut)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount > timeoutLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", timeoutLimit);
      $display("FAIL: see errors above");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rngState;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rngState = x;
    return x;
  endfunction

  task automatic compareValue(input logic [63:0] got, input logic [63:0] expected,
                              input string what);
    if (got !== expected) begin
      $display("[ERROR] time %0t: %s is %0h, expected %0h", $time, what, got, expected);
      $display("FAIL: see errors above");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  ////////////////////////////////////////////////
  // Model rules
  ////////////////////////////////////////////////

  // Index of the entry that translates this key or -1 on a miss
  function automatic int modelMatch(input logic [vpnBits-1:0] v, input logic [asidW-1:0] a);
    int found;
    logic segOk;
    found = -1;
    for (int i = 0; i < entries; i++) begin
      // Megapages skip the lowest segment and gigapages the two lowest
      case (mType[i])
        kilo: segOk = (v == mVpn[i]);
        mega: segOk = (v[26:9] == mVpn[i][26:9]);
        default: segOk = (v[26:18] == mVpn[i][26:18]);
      endcase
      if (mValid[i] && (mGlobal[i] || a == mAsid[i]) && segOk) begin
        found = i;
      end
    end
    return found;
  endfunction

  // Free lines go first, otherwise follow the tree from the root
  function automatic int modelVictim();
    int idx;
    int node;
    idx = -1;
    for (int i = entries - 1; i >= 0; i--) begin
      if (!mValid[i]) begin
        idx = i;
      end
    end
    if (idx < 0) begin
      idx = 0;
      node = 0;
      for (int d = 0; d < levels; d++) begin
        idx = 2 * idx + int'(mTree[node]);
        node = 2 * node + 1 + int'(mTree[node]);
      end
    end
    return idx;
  endfunction

  // Every node on the way down is turned to point away from the used leaf
  task automatic modelTouch(input int idx);
    int node;
    logic b;
    node = 0;
    for (int d = levels - 1; d >= 0; d--) begin
      b = idx[d];
      mTree[node] = !b;
      node = 2 * node + 1 + int'(b);
    end
  endtask

  // Large pages take their low physical segments from the virtual address
  function automatic logic [ppnBits-1:0] spliceExpected(input logic [ppnBits-1:0] p,
                                                        input logic [vpnBits-1:0] v,
                                                        input pageType t);
    logic [ppnBits-1:0] mask;
    mask = '0;
    if (t == mega) begin
      mask = 44'h1ff;
    end else if (t == giga) begin
      mask = 44'h3ffff;
    end
    return (p & ~mask) | ({17'd0, v} & mask);
  endfunction

  // Segment 2 is kept unique among valid lines so no two entries overlap
  function automatic logic [vpnBits-1:0] freshVpn();
    logic [31:0] r;
    logic [8:0] s2;
    logic clash;
    do begin
      r = xorshift32();
      s2 = r[8:0];
      clash = 1'b0;
      for (int i = 0; i < entries; i++) begin
        if (mValid[i] && mVpn[i][26:18] == s2) begin
          clash = 1'b1;
        end
      end
    end while (clash);
    r = xorshift32();
    return {s2, r[17:0]};
  endfunction

  function automatic logic [ppnBits-1:0] randomPpn();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = xorshift32();
    lo = xorshift32();
    return {hi[11:0], lo};
  endfunction

  function automatic pageType randomType();
    logic [31:0] r;
    r = xorshift32() % 3;
    return pageType'(r[1:0]);
  endfunction

  ////////////////////////////////////////////////
  // Handshake driver
  ////////////////////////////////////////////////

  // Starts 1 ns after an edge and returns 1 ns after the edge that drops ack
  task automatic runOp(input tlbOp o, input logic [vpnBits-1:0] v,
                       input logic [asidW-1:0] a, input logic [ppnBits-1:0] p,
                       input logic [permBits-1:0] pm, input pageType t,
                       output logic h, output logic [ppnBits-1:0] po,
                       output logic [permBits-1:0] pmo);
    int edges;
    int extra;
    logic [31:0] r;
    op = o;
    vpn = v;
    asid = a;
    ppnIn = p;
    permIn = pm;
    pageTypeIn = t;
    req = 1'b1;
    edges = 0;
    do begin
      @(posedge clk);
      #1;
      edges++;
    end while (!ack);
    // Two cycles after req is first sampled, which is the third edge after driving it
    compareValue(64'(edges), 64'd3, "ack latency in edges");
    h = hit;
    po = ppnOut;
    pmo = permOut;
    // Under back-pressure the result stays put and nothing new may start
    r = xorshift32();
    extra = int'(r[1:0]);
    repeat (extra) begin
      @(posedge clk);
      #1;
      compareValue(64'(ack), 64'd1, "ack while req held");
      compareValue(64'(hit), 64'(h), "hit while req held");
      compareValue(64'(ppnOut), 64'(po), "ppnOut while req held");
      compareValue(64'(permOut), 64'(pmo), "permOut while req held");
    end
    req = 1'b0;
    @(posedge clk);
    #1;
    compareValue(64'(ack), 64'd0, "ack after req low");
  endtask

  task automatic doLookup(input logic [vpnBits-1:0] v, input logic [asidW-1:0] a);
    int idx;
    logic h;
    logic [ppnBits-1:0] p;
    logic [permBits-1:0] pm;
    idx = modelMatch(v, a);
    runOp(lookup, v, a, '0, '0, kilo, h, p, pm);
    compareValue(64'(h), 64'(idx >= 0), "lookup hit");
    if (idx >= 0) begin
      compareValue(64'(p), 64'(spliceExpected(mPpn[idx], v, mType[idx])), "lookup ppn");
      compareValue(64'(pm), 64'(mPerm[idx]), "lookup perm");
      modelTouch(idx);
    end
  endtask

  // A key that already hits keeps its line, any other key takes the victim
  task automatic doFill(input logic [vpnBits-1:0] v, input logic [asidW-1:0] a,
                        input logic [ppnBits-1:0] p, input logic [permBits-1:0] pm,
                        input pageType t);
    int idx;
    logic h;
    logic [ppnBits-1:0] po;
    logic [permBits-1:0] pmo;
    idx = modelMatch(v, a);
    if (idx < 0) begin
      idx = modelVictim();
    end
    evictedVpn = mVpn[idx];
    evictedAsid = mAsid[idx];
    runOp(fill, v, a, p, pm, t, h, po, pmo);
    compareValue(64'(h), 64'd0, "fill hit");
    mValid[idx] = 1'b1;
    mVpn[idx] = v;
    mAsid[idx] = a;
    // G sits in bit 5 of the PTE flags
    mGlobal[idx] = pm[5];
    mType[idx] = t;
    mPpn[idx] = p;
    mPerm[idx] = pm;
    modelTouch(idx);
    lastVpn = v;
    lastAsid = a;
  endtask

  task automatic randomFill();
    logic [31:0] r;
    logic [vpnBits-1:0] v;
    v = freshVpn();
    r = xorshift32();
    doFill(v, r[15:0], randomPpn(), r[23:16], randomType());
  endtask

  // Flush drops every valid bit but leaves the tree alone
  task automatic doFlush();
    logic h;
    logic [ppnBits-1:0] po;
    logic [permBits-1:0] pmo;
    runOp(flush, '0, '0, '0, '0, kilo, h, po, pmo);
    compareValue(64'(h), 64'd0, "flush hit");
    for (int i = 0; i < entries; i++) begin
      mValid[i] = 1'b0;
    end
  endtask

  ////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    logic [vpnBits-1:0] v;
    int k;
    rst = 1'b1;
    req = 1'b0;
    op = lookup;
    vpn = '0;
    asid = '0;
    ppnIn = '0;
    permIn = '0;
    pageTypeIn = kilo;
    mTree = '0;
    for (int i = 0; i < entries; i++) begin
      mValid[i] = 1'b0;
    end
    repeat (8) @(posedge clk);
    #1 rst = 1'b0;
    @(posedge clk);
    #1;

    // Nothing is valid after reset
    repeat (resetLookups) begin
      r = xorshift32();
      doLookup(r[26:0], r[31:16]);
    end

    // Fill every line, then hit each exactly and with ignored segments changed
    repeat (entries) randomFill();
    for (int i = 0; i < entries; i++) begin
      doLookup(mVpn[i], mAsid[i]);
    end
    for (int i = 0; i < entries; i++) begin
      r = xorshift32();
      v = mVpn[i];
      if (mType[i] == mega) begin
        v[8:0] = r[8:0];
      end else if (mType[i] == giga) begin
        v[17:0] = r[17:0];
      end
      doLookup(v, mAsid[i]);
    end

    // Under a foreign ASID only global entries still hit
    for (int i = 0; i < entries; i++) begin
      r = xorshift32();
      doLookup(mVpn[i], mAsid[i] ^ (r[15:0] | 16'h1));
    end

    // Every line is valid now, so each fill pushes out the tree's choice
    repeat (evictRounds) begin
      randomFill();
      doLookup(evictedVpn, evictedAsid);
      doLookup(lastVpn, lastAsid);
    end

    // Refill of a key that hits rewrites its own line
    repeat (refillCount) begin
      r = xorshift32();
      k = int'(r[2:0]);
      doFill(mVpn[k], mAsid[k], randomPpn(), r[15:8], randomType());
      doLookup(mVpn[k], mAsid[k]);
    end

    doFlush();
    for (int i = 0; i < entries; i++) begin
      doLookup(mVpn[i], mAsid[i]);
    end
    repeat (postFlushFills) begin
      randomFill();
      doLookup(lastVpn, lastAsid);
    end

    $display("PASS: all tests");
    $finish;
  end

endmodule

// ==== sources.f ====
src/tlbPkg.sv
src/tlbLookupIf.sv
src/tlbCamLine.sv
src/tlbCam.sv
src/tlbRam.sv
src/tlbLru.sv
src/tlbCtrl.sv
src/tlb.sv
verification/tlbChk.sv
verification/tlbTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the TLB testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tlbTb -Mdir obj_dir -o tlbSim -f sources.f

# The log decides the result, so a failing run must not stop the script here
./obj_dir/tlbSim > sim.log 2>&1 || true
cat sim.log

if grep -qx "PASS: all tests" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
